// File: filelist.f
hdl/vrd_pkg.sv
hdl/line_fetch.sv
hdl/line_store.sv
hdl/line_reader.sv
hdl/video_rd_ctrl.sv
verification/axi_rd_mem_model.sv
verification/tb_video_rd_ctrl.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps -j 0
TOP       = tb_video_rd_ctrl
FILELIST  = filelist.f
BUILD     = obj_dir
SIM_BIN   = $(BUILD)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))
PASS_MSG  = Finished with no errors

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM_BIN)
	@out=$$(./$(SIM_BIN) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: verification/tb_video_rd_ctrl.sv
// ----------------------------------------------------------------------
// Video read control testbench
// Table-driven frames, AR address and lane data scoreboard, watchdog
// ----------------------------------------------------------------------
module tb_video_rd_ctrl;
	timeunit 1ns;
	timeprecision 100ps;
	import vrd_pkg::*;

	typedef struct packed {
		logic      en;                         // Display enable
		frm_slot_t wcnt;                       // Writer frame counter
		int        frames;                     // Frames to play
		int        rdy_dly;                    // ARREADY delay
		int        max_gap;                    // Longest RVALID gap
	} row_t;

	localparam int n_rows      = 5;
	localparam int porch_lines = 3;            // Two lines before and one after

	// en, wcnt, frames, arready delay, rvalid gap
	row_t rows [n_rows] = '{
		'{1'b1, 2'd2, 2, 0, 0},                 // Slot 0 then slot 1
		'{1'b1, 2'd0, 1, 3, 3},                 // Slot wraps to 3
		'{1'b0, 2'd1, 1, 0, 0},                 // Display off
		'{1'b1, 2'd3, 2, 1, 2},                 // Re-enable with slot 0 then 2
		'{1'b1, 2'd1, 1, 2, 5}                  // Long read gaps
	};

	logic      CLK_MIG1_UI = 1'b0;
	logic      XRST;
	logic      vx1_vs;
	logic      vx1_de;
	logic      video_disp_en;
	frm_slot_t video_rx_frm_wcnt;
	logic      axim_arready;
	logic      axim_rvalid;
	logic      axim_rlast;
	beat_t     axim_rdata;
	axi_addr_t axim_araddr;
	logic      axim_arvalid;
	lane_bus_t vx1_video_d;
	logic      vx1_video_vld;
	int        rdy_dly;                        // Memory model knobs
	int        max_gap;

	axi_addr_t  addr_q [$];                    // Accepted line addresses
	frm_slot_t  exp_slot;                      // Slot of current frame
	int         exp_line;
	int         out_beat;
	int         ar_count = 0;                  // AR handshakes so far
	int         lines_read = 0;                // Lines fully shown
	logic [2:0] de_hist = '0;                  // DE seen at the last three checks

	always #5 CLK_MIG1_UI = ~CLK_MIG1_UI;

	video_rd_ctrl DUT (.*);

	axi_rd_mem_model mem_model (
		.CLK_MIG1_UI, .arvalid(axim_arvalid), .araddr(axim_araddr), .ready_dly(rdy_dly),
		.max_gap, .arready(axim_arready), .rdata(axim_rdata), .rvalid(axim_rvalid),
		.rlast(axim_rlast)
	);

	// ------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------
	task automatic stop_on_error(string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1, "Stopped at %0t ns", $time);
	endtask

	task automatic check_addr(string name, axi_addr_t got, axi_addr_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_lanes(string name, lane_bus_t got, lane_bus_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_count(string name, line_cnt_t got, line_cnt_t limit);
		if (got > limit) begin
			stop_on_error($sformatf("Mismatch %s: got %h, expected at most %h", name, got, limit));
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
		end
	endtask

	// Fetched minus shown lines clipped to the count width
	function automatic line_cnt_t held_lines();
		int d;
		d = ar_count - lines_read;
		return (d > 3) ? line_cnt_t'(3) : line_cnt_t'(d);
	endfunction

	// Line field at bit 14 and slot field at bit 26
	function automatic axi_addr_t expected_addr(frm_slot_t slot, int line);
		return (axi_addr_t'(slot) << 26) | (axi_addr_t'(line_idx_t'(line)) << 14);
	endfunction

	function automatic lane_bus_t expected_lanes(axi_addr_t addr, int beat);
		lane_bus_t lanes;
		int        k;
		for (k = 0; k < lane_count; k++) begin
			lanes[k*lane_bits +: lane_bits] = {addr[27:26], addr[25:14], beat[3:0], k[3:0],
				addr[21:14] ^ {beat[3:0], k[3:0]}};
		end
		return lanes;
	endfunction

	// Line period long enough for a worst case burst
	function automatic int blank_cycles(int r);
		return line_beats * (rows[r].max_gap + 1) + rows[r].rdy_dly + 8;
	endfunction

	// Scoreboard sampled mid cycle
	always @(negedge CLK_MIG1_UI) begin
		if (!video_disp_en) begin
			check_bit("axim_arvalid", axim_arvalid, 1'b0);
			check_bit("vx1_video_vld", vx1_video_vld, 1'b0);
		end else begin
			check_bit("vx1_video_vld", vx1_video_vld, de_hist[2]); // Three cycles behind DE
		end
		de_hist = {de_hist[1:0], vx1_de};
		if (axim_arvalid && axim_arready) begin
			check_addr("axim_araddr", axim_araddr, expected_addr(exp_slot, exp_line));
			addr_q.push_back(axim_araddr);
			exp_line++;
			ar_count++;
			check_count("lines held", held_lines(), line_cnt_t'(2));
		end
		if (vx1_video_vld) begin
			if (addr_q.size() == 0) stop_on_error("Lane data valid with no line fetched");
			check_lanes("vx1_video_d", vx1_video_d, expected_lanes(addr_q[0], out_beat));
			out_beat++;
			if (out_beat == line_beats) begin
				out_beat = 0;
				void'(addr_q.pop_front());
				lines_read++;
			end
		end
	end

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------
	task automatic next_cycles(int n);
		repeat (n) @(posedge CLK_MIG1_UI);
		#1;
	endtask

	task automatic play_frame(int blank);
		int ln;
		vx1_vs = 1'b0;                         // Vsync low pulse
		next_cycles(4);
		vx1_vs = 1'b1;
		next_cycles(2 * (line_beats + blank));
		for (ln = 0; ln < frame_lines; ln++) begin
			vx1_de = 1'b1;
			next_cycles(line_beats);
			vx1_de = 1'b0;
			next_cycles(blank);
		end
		next_cycles(line_beats + blank);       // Front porch
	endtask

	initial begin
		int   r;
		int   f;
		int   row_ar;
		logic first_frm;
		XRST              = 1'b0;
		vx1_vs            = 1'b1;
		vx1_de            = 1'b0;
		video_disp_en     = 1'b0;
		video_rx_frm_wcnt = '0;
		rdy_dly           = 0;
		max_gap           = 0;
		exp_slot          = '0;
		exp_line          = 0;
		out_beat          = 0;
		first_frm         = 1'b1;
		repeat (3) @(posedge CLK_MIG1_UI);
		#1;
		XRST = 1'b1;
		next_cycles(2);
		check_bit("axim_arvalid", axim_arvalid, 1'b0);
		check_bit("vx1_video_vld", vx1_video_vld, 1'b0);
		for (r = 0; r < n_rows; r++) begin
			if (rows[r].en && !video_disp_en) first_frm = 1'b1;
			video_disp_en     = rows[r].en;
			video_rx_frm_wcnt = rows[r].wcnt;
			rdy_dly           = rows[r].rdy_dly;
			max_gap           = rows[r].max_gap;
			row_ar            = ar_count;
			for (f = 0; f < rows[r].frames; f++) begin
				exp_slot  = first_frm ? frm_slot_t'(0) : frm_slot_t'((int'(rows[r].wcnt) + 3) % 4);
				exp_line  = 0;
				first_frm = 1'b0;
				play_frame(blank_cycles(r));
			end
			if (rows[r].en && (ar_count - row_ar != rows[r].frames * frame_lines)) begin
				stop_on_error("Wrong number of line fetches in a table row");
			end
			check_count("lines held at row end", held_lines(), line_cnt_t'(0));
		end
		$display("Finished with no errors");
		$finish;
	end

	// Twice the summed frame lengths
	initial begin
		longint limit;
		int     r;
		limit = 1000;
		for (r = 0; r < n_rows; r++) begin
			limit += 20 * longint'(rows[r].frames * (frame_lines + porch_lines + 1)
				* (line_beats + blank_cycles(r) + line_beats * rows[r].max_gap));
		end
		#(limit);
		stop_on_error("Watchdog timeout, the table did not finish in time");
	end

endmodule

// File: verification/axi_rd_mem_model.sv
// ----------------------------------------------------------------------
// AXI read slave model
// Returns line bursts with beat words built from address and beat index
// ----------------------------------------------------------------------
module axi_rd_mem_model (
	input  logic               CLK_MIG1_UI,    // Memory UI clock
	input  logic               arvalid,        // Read address valid
	input  vrd_pkg::axi_addr_t araddr,         // Read address
	input  int                 ready_dly,      // Cycles before ARREADY
	input  int                 max_gap,        // Longest idle gap between beats
	output logic               arready,        // Read address ready
	output vrd_pkg::beat_t     rdata,          // Read beat
	output logic               rvalid,         // Read beat valid
	output logic               rlast           // Last beat of burst
);
	timeunit 1ns;
	timeprecision 100ps;
	import vrd_pkg::*;

	integer seed = 94249;                      // Gap sequence seed

	// Word k: pad, slot, line, beat, lane, then a mixed byte
	function automatic beat_t beat_data(axi_addr_t addr, int b);
		beat_t beat;
		int    k;
		for (k = 0; k < lane_count; k++) begin
			beat[k*word_bits +: word_bits] = {2'b10, addr[27:26], addr[25:14], b[3:0], k[3:0],
				addr[21:14] ^ {b[3:0], k[3:0]}};
		end
		return beat;
	endfunction

	task automatic after_edge();
		@(posedge CLK_MIG1_UI);
		#1;                                    // Drive just past the edge
	endtask

	initial begin
		axi_addr_t addr;
		int        b;
		int        gap;
		arready = 1'b0;
		rvalid  = 1'b0;
		rlast   = 1'b0;
		rdata   = '0;
		forever begin
			after_edge();
			if (arvalid) begin
				addr = araddr;
				repeat (ready_dly) after_edge();
				arready = 1'b1;
				after_edge();                  // Address handshake
				arready = 1'b0;
				for (b = 0; b < line_beats; b++) begin
					gap = (max_gap == 0) ? 0 : $unsigned($random(seed)) % (max_gap + 1);
					repeat (gap) after_edge();
					rvalid = 1'b1;
					rlast  = (b == line_beats - 1);
					rdata  = beat_data(addr, b);
					after_edge();
					rvalid = 1'b0;
					rlast  = 1'b0;
				end
			end
		end
	end

endmodule

// File: hdl/video_rd_ctrl.sv
// ----------------------------------------------------------------------
// Video read control top
// DDR line fetch, ping-pong line buffer and V-by-One lane output
// ----------------------------------------------------------------------
module video_rd_ctrl (
	input  logic               CLK_MIG1_UI,        // Memory UI clock
	input  logic               XRST,               // Async reset, active low
	input  logic               vx1_vs,             // V-by-One vsync
	input  logic               vx1_de,             // V-by-One data enable
	input  logic               video_disp_en,      // Display enable
	input  vrd_pkg::frm_slot_t video_rx_frm_wcnt,  // Writer frame counter
	input  logic               axim_arready,       // AR ready
	input  vrd_pkg::beat_t     axim_rdata,         // Read data
	input  logic               axim_rvalid,        // Read valid
	input  logic               axim_rlast,         // Read last
	output vrd_pkg::axi_addr_t axim_araddr,        // Read address
	output logic               axim_arvalid,       // Read address valid
	output vrd_pkg::lane_bus_t vx1_video_d,        // Lane data
	output logic               vx1_video_vld       // Lane data valid
);
	import vrd_pkg::*;

	logic      line_done;                          // Fetch to store
	logic      buf_full;                           // Store to fetch
	logic      rd_en;                              // Reader to store
	buf_addr_t rd_addr;
	logic      line_read;
	beat_t     rd_data;                            // Store to reader

	// ------------------------------------------------------------------
	// Producer, buffer, consumer
	// ------------------------------------------------------------------
	line_fetch u_fetch (
		.CLK_MIG1_UI, .XRST, .vx1_vs, .video_disp_en, .video_rx_frm_wcnt,
		.axim_arready, .axim_rvalid, .axim_rlast, .buf_full,
		.axim_araddr, .axim_arvalid, .line_done
	);

	line_store u_store (
		.CLK_MIG1_UI, .XRST, .video_disp_en, .axim_rvalid, .axim_rdata,
		.line_done, .rd_en, .rd_addr, .line_read, .rd_data, .buf_full
	);

	line_reader u_reader (
		.CLK_MIG1_UI, .XRST, .vx1_vs, .vx1_de, .video_disp_en, .rd_data,
		.rd_en, .rd_addr, .line_read, .vx1_video_d, .vx1_video_vld
	);

endmodule

// File: hdl/line_reader.sv
// ----------------------------------------------------------------------
// Line reader
// Reads buffered lines on data enable and drives the V-by-One lanes
// ----------------------------------------------------------------------
module line_reader (
	input  logic               CLK_MIG1_UI,    // Memory UI clock
	input  logic               XRST,           // Async reset, active low
	input  logic               vx1_vs,         // V-by-One vsync
	input  logic               vx1_de,         // V-by-One data enable
	input  logic               video_disp_en,  // Display enable
	input  vrd_pkg::beat_t     rd_data,        // Beat from line store
	output logic               rd_en,          // Buffer read enable
	output vrd_pkg::buf_addr_t rd_addr,        // Buffer read address
	output logic               line_read,      // Line read out strobe
	output vrd_pkg::lane_bus_t vx1_video_d,    // Lane data
	output logic               vx1_video_vld   // Lane data valid
);
	import vrd_pkg::*;

	logic [2:0] disp_sr;                       // Delayed display enable
	logic [2:0] de_sr;                         // Delayed data enable
	logic       read_on;                       // Read enable, armed at vsync
	logic [1:0] ren_sr;                        // rd_en delay to valid
	logic       rd_bank;                       // Bank being read
	beat_idx_t  rd_beat;                       // Beat within bank

	// ------------------------------------------------------------------
	// Enables
	// ------------------------------------------------------------------
	always_ff @(posedge CLK_MIG1_UI or negedge XRST) begin
		if (!XRST) begin
			disp_sr <= '0;
			de_sr   <= '0;
		end else begin
			disp_sr <= {disp_sr[1:0], video_disp_en};
			de_sr   <= {de_sr[1:0], vx1_de};
		end
	end

	// Output starts on a vsync so lines follow frame order
	always_ff @(posedge CLK_MIG1_UI or negedge XRST) begin
		if (!XRST) begin
			read_on <= 1'b0;
		end else if (!disp_sr[2]) begin
			read_on <= 1'b0;                   // Display off
		end else if (vx1_vs) begin
			read_on <= 1'b1;
		end
	end

	assign rd_en     = de_sr[0] & read_on;
	assign line_read = (de_sr[2:1] == 2'b10) && read_on; // DE falling edge

	// ------------------------------------------------------------------
	// Read address
	// ------------------------------------------------------------------
	always_ff @(posedge CLK_MIG1_UI or negedge XRST) begin
		if (!XRST) begin
			rd_bank <= 1'b0;
			rd_beat <= '0;
		end else if (!disp_sr[2]) begin
			rd_bank <= 1'b0;
			rd_beat <= '0;
		end else if (line_read) begin
			rd_bank <= ~rd_bank;               // Next line in other bank
			rd_beat <= '0;
		end else if (rd_en) begin
			rd_beat <= rd_beat + beat_idx_t'(1);
		end
	end

	assign rd_addr = {rd_bank, rd_beat};

	// ------------------------------------------------------------------
	// Lane output
	// ------------------------------------------------------------------
	always_ff @(posedge CLK_MIG1_UI or negedge XRST) begin
		if (!XRST) begin
			ren_sr <= '0;
		end else begin
			ren_sr <= {ren_sr[0], rd_en};      // RAM read plus lane register
		end
	end

	// Low 30 bits of each 32-bit word
	always_ff @(posedge CLK_MIG1_UI) begin
		for (int k = 0; k < lane_count; k++) begin
			vx1_video_d[k*lane_bits +: lane_bits] <= rd_data[k*word_bits +: lane_bits];
		end
	end

	assign vx1_video_vld = ren_sr[1];

endmodule

// File: hdl/line_store.sv
// ----------------------------------------------------------------------
// Ping-pong line store
// Two line banks written from AXI read data, with line occupancy count
// ----------------------------------------------------------------------
module line_store (
	input  logic               CLK_MIG1_UI,    // Memory UI clock
	input  logic               XRST,           // Async reset, active low
	input  logic               video_disp_en,  // Display enable
	input  logic               axim_rvalid,    // Read beat valid
	input  vrd_pkg::beat_t     axim_rdata,     // Read beat
	input  logic               line_done,      // Line fully written
	input  logic               rd_en,          // Buffer read enable
	input  vrd_pkg::buf_addr_t rd_addr,        // Buffer read address
	input  logic               line_read,      // Line fully read out
	output vrd_pkg::beat_t     rd_data,        // Read beat, one cycle after rd_en
	output logic               buf_full        // Both banks occupied
);
	import vrd_pkg::*;

	beat_t     mem [2*line_beats];             // Bank 0 then bank 1
	logic      wr_en_q;                        // Registered beat valid
	beat_t     wr_data_q;                      // Registered beat
	logic      line_done_d;                    // Line end, one cycle late
	logic      wr_bank;                        // Bank being filled
	beat_idx_t wr_beat;                        // Beat within bank
	line_cnt_t line_cnt;                       // Lines held

	// ------------------------------------------------------------------
	// Write side
	// ------------------------------------------------------------------
	always_ff @(posedge CLK_MIG1_UI or negedge XRST) begin
		if (!XRST) begin
			wr_en_q     <= 1'b0;
			line_done_d <= 1'b0;
		end else begin
			wr_en_q     <= axim_rvalid;        // RREADY always high
			line_done_d <= line_done;
		end
	end

	always_ff @(posedge CLK_MIG1_UI) begin
		wr_data_q <= axim_rdata;
	end

	// Beat field wraps inside its bank, the bank only flips at line end
	always_ff @(posedge CLK_MIG1_UI or negedge XRST) begin
		if (!XRST) begin
			wr_bank <= 1'b0;
			wr_beat <= '0;
		end else if (!video_disp_en) begin
			wr_bank <= 1'b0;                   // Display off
			wr_beat <= '0;
		end else if (line_done_d) begin
			wr_bank <= ~wr_bank;               // Other bank for next line
			wr_beat <= '0;
		end else if (wr_en_q) begin
			wr_beat <= wr_beat + beat_idx_t'(1);
		end
	end

	// ------------------------------------------------------------------
	// Line memory
	// ------------------------------------------------------------------
	always_ff @(posedge CLK_MIG1_UI) begin
		if (wr_en_q) begin
			mem[{wr_bank, wr_beat}] <= wr_data_q;
		end
		if (rd_en) begin
			rd_data <= mem[rd_addr];           // Registered read port
		end
	end

	// ------------------------------------------------------------------
	// Occupancy
	// ------------------------------------------------------------------
	always_ff @(posedge CLK_MIG1_UI or negedge XRST) begin
		if (!XRST) begin
			line_cnt <= '0;
		end else if (!video_disp_en) begin
			line_cnt <= '0;
		end else if (line_done && !line_read) begin
			line_cnt <= line_cnt + line_cnt_t'(1); // One line in
		end else if (!line_done && line_read) begin
			line_cnt <= line_cnt - line_cnt_t'(1); // One line out
		end
	end

	assign buf_full = (line_cnt == line_cnt_t'(buf_lines));

endmodule

// File: hdl/line_fetch.sv
// ----------------------------------------------------------------------
// Line fetcher
// Tracks frames on vsync and issues one AXI read burst per video line
// ----------------------------------------------------------------------
module line_fetch (
	input  logic               CLK_MIG1_UI,        // Memory UI clock
	input  logic               XRST,               // Async reset, active low
	input  logic               vx1_vs,             // V-by-One vsync
	input  logic               video_disp_en,      // Display enable
	input  vrd_pkg::frm_slot_t video_rx_frm_wcnt,  // Writer frame counter
	input  logic               axim_arready,       // AR ready from slave
	input  logic               axim_rvalid,        // Read beat valid
	input  logic               axim_rlast,         // Last beat of burst
	input  logic               buf_full,           // Both banks hold a line
	output vrd_pkg::axi_addr_t axim_araddr,        // Read address
	output logic               axim_arvalid,       // Read address valid
	output logic               line_done           // Burst finished strobe
);
	import vrd_pkg::*;

	logic [3:0]   vs_sr;                           // Vsync shift register
	logic         vs_fall;                         // Vsync falling edge
	logic         frm_start;                       // Registered frame start
	logic         fetch_en;                        // Fetching lines of a frame
	logic         second_frm;                      // A frame start was already seen
	logic         line_done_q;                     // Line end, one cycle late
	logic         last_line;                       // Current line is last of frame
	line_idx_t    line_idx;                        // Line being fetched
	frm_slot_t    frm_slot;                        // Slot being fetched
	fetch_state_t state;                           // Read master state

	// ------------------------------------------------------------------
	// Frame start
	// ------------------------------------------------------------------
	always_ff @(posedge CLK_MIG1_UI or negedge XRST) begin
		if (!XRST) begin
			vs_sr     <= '0;
			frm_start <= 1'b0;
		end else begin
			vs_sr     <= {vs_sr[2:0], vx1_vs};     // Shift in vsync
			frm_start <= vs_fall;
		end
	end

	assign vs_fall = (vs_sr[3:2] == 2'b10);        // High then low

	// ------------------------------------------------------------------
	// Fetch enable and frame tracking
	// ------------------------------------------------------------------
	assign last_line = (line_idx == line_idx_t'(frame_lines - 1));

	always_ff @(posedge CLK_MIG1_UI or negedge XRST) begin
		if (!XRST) begin
			fetch_en <= 1'b0;
		end else if (!video_disp_en) begin
			fetch_en <= 1'b0;                      // Display off
		end else if (state == line_end && last_line) begin
			fetch_en <= 1'b0;                      // Frame fully fetched
		end else if (frm_start) begin
			fetch_en <= 1'b1;                      // New frame
		end
	end

	always_ff @(posedge CLK_MIG1_UI or negedge XRST) begin
		if (!XRST) begin
			second_frm <= 1'b0;
		end else if (!video_disp_en) begin
			second_frm <= 1'b0;
		end else if (frm_start) begin
			second_frm <= 1'b1;                    // Armed by first frame
		end
	end

	// The first frame after enable reads slot 0 from address zero
	always_ff @(posedge CLK_MIG1_UI or negedge XRST) begin
		if (!XRST) begin
			line_idx <= '0;
			frm_slot <= '0;
		end else if (!video_disp_en) begin
			line_idx <= '0;
			frm_slot <= '0;
		end else if (frm_start && second_frm) begin
			line_idx <= '0;
			frm_slot <= video_rx_frm_wcnt - frm_slot_t'(1); // Slot behind writer
		end else if (line_done_q) begin
			line_idx <= line_idx + line_idx_t'(1); // Next line
		end
	end

	always_ff @(posedge CLK_MIG1_UI or negedge XRST) begin
		if (!XRST) begin
			line_done_q <= 1'b0;
		end else begin
			line_done_q <= line_done;
		end
	end

	// Offset bits stay zero, upper bits zero-extended
	assign axim_araddr = axi_addr_t'({frm_slot, line_idx}) << addr_off_bits;

	// ------------------------------------------------------------------
	// AXI read master
	// ------------------------------------------------------------------
	always_ff @(posedge CLK_MIG1_UI or negedge XRST) begin
		if (!XRST) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (fetch_en && !buf_full) begin   // Room for a line
						state <= addr_info;
					end
				end
				addr_info: begin
					state <= addr_valid;
				end
				addr_valid: begin
					if (axim_arready) begin            // Address accepted
						state <= data_wait;
					end
				end
				data_wait: begin
					if (axim_rvalid) begin             // First beat
						state <= data;
					end
				end
				data: begin
					if (axim_rvalid && axim_rlast) begin
						state <= line_end;
					end
				end
				line_end: begin
					state <= idle;
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	assign axim_arvalid = (state == addr_valid);
	assign line_done    = (state == line_end);     // One cycle per line

endmodule

// File: hdl/vrd_pkg.sv
// ----------------------------------------------------------------------
// Video read control definitions
// Line geometry, vector types and the fetch FSM encoding
// ----------------------------------------------------------------------
package vrd_pkg;

	// ------------------------------------------------------------------
	// Geometry
	// ------------------------------------------------------------------
	localparam int line_beats    = 16;                   // Beats per line burst
	localparam int frame_lines   = 60;                   // Lines per frame
	localparam int lane_count    = 16;                   // V-by-One output lanes
	localparam int lane_bits     = 30;                   // Pixel bits per lane
	localparam int word_bits     = 32;                   // Stored bits per lane
	localparam int addr_off_bits = 14;                   // Byte offset field of address
	localparam int beat_idx_bits = $clog2(line_beats);   // Beat field of buffer address
	localparam int buf_lines     = 2;                    // Lines held by ping-pong buffer

	// ------------------------------------------------------------------
	// Vector types
	// ------------------------------------------------------------------
	// Address map [13:0] offset, [25:14] line, [27:26] slot, [31:28] zero
	typedef logic [31:0] axi_addr_t;                     // AXI read address

	typedef logic [11:0] line_idx_t;                     // Line in frame

	typedef logic [1:0] frm_slot_t;                      // Frame slot in DDR

	typedef logic [lane_count*word_bits-1:0] beat_t;     // One 64-byte beat

	typedef logic [beat_idx_bits-1:0] beat_idx_t;        // Beat within line

	typedef logic [beat_idx_bits:0] buf_addr_t;          // MSB selects bank

	typedef logic [lane_count*lane_bits-1:0] lane_bus_t; // Lane k at bit 30k

	typedef logic [1:0] line_cnt_t;                      // Lines held, 0..2

	// ------------------------------------------------------------------
	// Fetch FSM
	// ------------------------------------------------------------------
	// One-hot state encoding
	typedef enum logic [5:0] {
		idle       = 6'h01,                              // Wait for enable and room
		addr_info  = 6'h02,                              // Address setup
		addr_valid = 6'h04,                              // ARVALID high
		data_wait  = 6'h08,                              // Wait first beat
		data       = 6'h10,                              // Beats until RLAST
		line_end   = 6'h20                               // Line complete strobe
	} fetch_state_t;

endpackage
